// ==== pip_core.f ====
verilog/pip_pkg.sv
verilog/id_ex_if.sv
verilog/inst_fetch.sv
verilog/reg_file.sv
verilog/inst_decode.sv
verilog/id_ex_buf.sv
verilog/exec_stage.sv
verilog/pip_core.sv
bench/pip_core_asserts.sv
bench/pip_core_tb.sv

// ==== Bender.yml ====
package:
  name: pip_core

sources:
  - verilog/pip_pkg.sv
  - verilog/id_ex_if.sv
  - verilog/inst_fetch.sv
  - verilog/reg_file.sv
  - verilog/inst_decode.sv
  - verilog/id_ex_buf.sv
  - verilog/exec_stage.sv
  - verilog/pip_core.sv
  - target: simulation
    files:
      - bench/pip_core_asserts.sv
      - bench/pip_core_tb.sv

// ==== bench/pip_core_tb.sv ====
`timescale 1ns/1ps

module pip_core_tb;

  localparam int num_programs = 7;
  localparam int wd_cycles    = num_programs * pip_pkg::imem_words * 3 + 100;

  logic                        clock, reset, run, imem_we;
  logic [pip_pkg::imem_aw-1:0] imem_addr;
  logic [31:0]                 imem_wdata;
  logic                        wb_valid;
  logic [4:0]                  wb_reg;
  logic [31:0]                 wb_data;

  logic [31:0] lfsr = 32'hf91038ae;
  logic [31:0] prog [$];
  logic [31:0] regs_m [32];
  logic [31:0] mem_m [16];
  logic [4:0]  exp_reg [$];
  logic [31:0] exp_val [$];
  logic [4:0]  er;
  logic [31:0] ev;
  string       cur_test;
  int          value_errors = 0;
  int          proto_errors = 0;

  logic [5:0] r_fn [16] = '{6'd0, 6'd2, 6'd3, 6'd4, 6'd6, 6'd7, 6'd32, 6'd33,
                            6'd34, 6'd35, 6'd36, 6'd37, 6'd38, 6'd39, 6'd42, 6'd43};
  logic [5:0] i_opc [8] = '{6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f};

  pip_core DUT (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  function automatic logic [31:0] take(input int n);
    logic [31:0] v;
    logic        fb;
    v = 32'd0;
    for (int k = 0; k < n; k++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [4:0] rnd_reg();
    return 5'(1 + take(3) % 7); // r1..r7 keeps hazards frequent
  endfunction

  // kinds 0..15 are R-format, 16..23 immediates
  function automatic logic [31:0] alu_word(input int kind, input logic [4:0] d, s, t);
    if (kind < 16)
      return {6'h00, s, t, d, 5'(take(5)), r_fn[kind]};
    return {i_opc[kind-16], s, d, 16'(take(16))};
  endfunction

  function automatic void model_exec(input logic [31:0] w);
    pip_pkg::inst_t iw;
    logic [31:0] a, b, se, ze, r, addr;
    logic        wr;
    logic [4:0]  d;
    iw   = w;
    a    = regs_m[iw.r.rs];
    b    = regs_m[iw.r.rt];
    se   = {{16{iw.i.imm[15]}}, iw.i.imm};
    ze   = {16'd0, iw.i.imm};
    addr = a + se;
    wr   = 1'b1;
    d    = iw.i.rt;
    r    = 32'd0;
    case (iw.r.opc)
      6'h00: begin
        d = iw.r.rd;
        case (iw.r.funct)
          6'd0:         r = b << iw.r.shamt;
          6'd2:         r = b >> iw.r.shamt;
          6'd3:         r = $signed(b) >>> iw.r.shamt;
          6'd4:         r = b << a[4:0];
          6'd6:         r = b >> a[4:0];
          6'd7:         r = $signed(b) >>> a[4:0];
          6'd32, 6'd33: r = a + b;
          6'd34, 6'd35: r = a - b;
          6'd36:        r = a & b;
          6'd37:        r = a | b;
          6'd38:        r = a ^ b;
          6'd39:        r = ~(a | b);
          6'd42:        r = {31'd0, $signed(a) < $signed(b)};
          6'd43:        r = {31'd0, a < b};
          default:      wr = 1'b0;
        endcase
      end
      6'h08, 6'h09: r = a + se;
      6'h0a:        r = {31'd0, $signed(a) < $signed(se)};
      6'h0b:        r = {31'd0, a < se};
      6'h0c:        r = a & ze;
      6'h0d:        r = a | ze;
      6'h0e:        r = a ^ ze;
      6'h0f:        r = {iw.i.imm, 16'd0};
      6'h23:        r = mem_m[addr[5:2]];
      6'h2b: begin
        mem_m[addr[5:2]] = b;
        wr = 1'b0;
      end
      default: wr = 1'b0;
    endcase
    if (wr && d != 5'd0) begin
      regs_m[d] = r;
      exp_reg.push_back(d);
      exp_val.push_back(r);
    end
  endfunction

  // random values into r1..r7, lui block then ori block so nothing depends closely
  task automatic add_reg_init();
    for (int r = 1; r < 8; r++)
      prog.push_back(alu_word(23, 5'(r), 5'd0, 5'd0));
    for (int r = 1; r < 8; r++)
      prog.push_back(alu_word(21, 5'(r), 5'(r), 5'd0));
  endtask

  // random register values, then every data word written
  task automatic add_mem_init();
    add_reg_init();
    for (int m = 0; m < 16; m++)
      prog.push_back({6'h2b, 5'd0, rnd_reg(), 16'(m * 4)});
  endtask

  function automatic logic [31:0] mem_word(input logic [5:0] opc, input logic [4:0] t);
    return {opc, 5'd0, t, 10'd0, 4'(take(4)), 2'd0};
  endfunction

  task automatic run_program(input string name);
    int waited;
    cur_test = name;
    @(negedge clock);
    reset = 1'b1;
    run   = 1'b0;
    repeat (8) @(negedge clock);
    reset = 1'b0;
    for (int r = 0; r < 32; r++)
      regs_m[r] = 32'd0;
    exp_reg.delete();
    exp_val.delete();
    for (int i = 0; i < prog.size(); i++) begin
      imem_we    = 1'b1;
      imem_addr  = pip_pkg::imem_aw'(i);
      imem_wdata = prog[i];
      model_exec(prog[i]);
      @(negedge clock);
    end
    imem_we = 1'b0;
    run     = 1'b1;
    waited  = 0;
    while (exp_reg.size() > 0 && waited < 2 * pip_pkg::imem_words + 20) begin
      @(posedge clock);
      waited++;
    end
    if (exp_reg.size() > 0) begin
      $display("[%s] %0d expected writebacks never appeared", name, exp_reg.size());
      proto_errors++;
      exp_reg.delete();
      exp_val.delete();
    end
    repeat (8) @(negedge clock); // catch extra writebacks
    run = 1'b0;
    prog.delete();
  endtask

  always @(negedge clock) begin
    if (!reset && wb_valid === 1'b1) begin
      if (exp_reg.size() == 0) begin
        $display("[%s] writeback to r%0d when none was expected", cur_test, wb_reg);
        proto_errors++;
      end else begin
        er = exp_reg.pop_front();
        ev = exp_val.pop_front();
        if (wb_reg !== er || wb_data !== ev) begin
          $display("** Error [%s] expected r%0d=%h, actual r%0d=%h",
                   cur_test, er, ev, wb_reg, wb_data);
          value_errors++;
        end
      end
    end
  end

  initial begin
    repeat (wd_cycles) @(posedge clock);
    $display("watchdog expired, simulation did not finish in time");
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    logic [4:0] r, r2;
    reset      = 1'b1;
    run        = 1'b0;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = 32'd0;
    for (int m = 0; m < 16; m++)
      mem_m[m] = 32'd0;

    for (int half = 0; half < 2; half++) begin
      add_reg_init();
      for (int k = half * 12; k < half * 12 + 12; k++) begin
        repeat (3) prog.push_back(32'd0); // no hazards
        prog.push_back(alu_word(k, rnd_reg(), rnd_reg(), rnd_reg()));
      end
      run_program(half == 0 ? "independent_a" : "independent_b");
    end

    for (int i = 0; i < 48; i++)
      prog.push_back(alu_word(take(5) % 24, rnd_reg(), rnd_reg(), rnd_reg()));
    run_program("dependent");

    add_mem_init();
    for (int i = 0; i < 9; i++) begin
      r = rnd_reg();
      prog.push_back(mem_word(6'h23, r));
      prog.push_back(alu_word(take(5) % 24, rnd_reg(), r, r)); // uses r at once
    end
    run_program("load_use");

    add_mem_init();
    for (int i = 0; i < 6; i++) begin
      r  = rnd_reg();
      r2 = rnd_reg();
      prog.push_back(mem_word(6'h23, r));
      prog.push_back({6'h2b, 5'd0, r, 16'(4 * i)});
      prog.push_back({6'h23, 5'd0, r2, 16'(4 * i)});
    end
    run_program("store_from_load");

    for (int i = 0; i < 12; i++) begin
      prog.push_back(alu_word(take(5) % 24, rnd_reg(), rnd_reg(), rnd_reg()));
      if (i % 2)
        prog.push_back({6'h3f, 26'(take(26))});
      else
        prog.push_back({6'h00, 20'(take(20)), 6'd1});
      prog.push_back(alu_word(take(5) % 24, 5'd0, rnd_reg(), rnd_reg()));
    end
    run_program("unknown_and_r0");

    for (int i = 1; i < 8; i++)
      prog.push_back({6'h00, 5'(i), 5'd0, 5'(i), 5'd0, 6'd33}); // reads r_i after reset
    for (int i = 0; i < 20; i++)
      prog.push_back(alu_word(take(5) % 24, rnd_reg(), rnd_reg(), rnd_reg()));
    run_program("reset_clear");

    $display("value errors: %0d, missing or extra writebacks: %0d", value_errors, proto_errors);
    if (value_errors == 0 && proto_errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== bench/pip_core_asserts.sv ====
`timescale 1ns/1ps

module pip_core_asserts (
  input logic       clock,
  input logic       reset,
  input logic       stall,
  input logic       wb_valid,
  input logic [4:0] wb_reg
);

  // a load-use bubble is always a single cycle
  single_stall: assert property (@(posedge clock) disable iff (reset) stall |=> !stall)
    else $error("stall held for two cycles in a row");

  no_r0_write: assert property (@(posedge clock) disable iff (reset) wb_valid |-> wb_reg != 5'd0)
    else $error("writeback to register 0");

  quiet_in_reset: assert property (@(posedge clock) reset |=> !wb_valid)
    else $error("wb_valid high during reset");

endmodule

bind pip_core pip_core_asserts u_asserts (
  .clock    (clock),
  .reset    (reset),
  .stall    (stall),
  .wb_valid (wb_valid),
  .wb_reg   (wb_reg)
);

// ==== verilog/pip_core.sv ====
`timescale 1ns/1ps

module pip_core (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        run,
  input  logic                        imem_we,
  input  logic [pip_pkg::imem_aw-1:0] imem_addr,
  input  logic [31:0]                 imem_wdata,
  output logic                        wb_valid,
  output logic [4:0]                  wb_reg,
  output logic [31:0]                 wb_data
);

  pip_pkg::inst_t inst;
  logic           inst_valid;
  logic           stall;
  logic [4:0]     rd_addr1, rd_addr2;
  logic [31:0]    rd_data1, rd_data2;
  logic [4:0]     ex_mem_dest_reg;
  logic           ex_mem_dest_valid;

  id_ex_if dec_out ();
  id_ex_if ex_in ();

  inst_fetch u_fetch (
    .clock, .reset, .run, .stall, .imem_we, .imem_addr, .imem_wdata,
    .inst, .inst_valid
  );

  reg_file u_regs (
    .clock, .reset, .rd_addr1, .rd_addr2,
    .wr_en   (wb_valid),
    .wr_addr (wb_reg),
    .wr_data (wb_data),
    .rd_data1, .rd_data2
  );

  inst_decode u_decode (
    .inst, .inst_valid, .rd_data1, .rd_data2,
    .ex_in   (ex_in),
    .ex_mem_dest_reg, .ex_mem_dest_valid,
    .rd_addr1, .rd_addr2, .stall,
    .dec_out (dec_out)
  );

  id_ex_buf u_buf (
    .clock, .reset, .stall,
    .dec_out (dec_out),
    .ex_in   (ex_in)
  );

  exec_stage u_exec (
    .clock, .reset,
    .ex_in (ex_in),
    .ex_mem_dest_reg, .ex_mem_dest_valid,
    .wb_valid, .wb_reg, .wb_data
  );

endmodule

// ==== verilog/exec_stage.sv ====
`timescale 1ns/1ps

module exec_stage (
  input  logic        clock,
  input  logic        reset,
  id_ex_if.sink       ex_in,
  output logic [4:0]  ex_mem_dest_reg,
  output logic        ex_mem_dest_valid,
  output logic        wb_valid,
  output logic [4:0]  wb_reg,
  output logic [31:0] wb_data
);

  logic [31:0] a_op, b_reg_val, b_op, alu_out, result;
  logic [4:0]  sh;
  logic        set_bit;

  logic [31:0] ex_mem_result, ex_mem_store_data;
  logic        ex_mem_late, ex_mem_load, ex_mem_store;
  logic [31:0] store_data;
  logic [pip_pkg::dmem_aw-1:0] dmem_addr;
  logic [31:0] dmem [pip_pkg::dmem_words];

  always_comb begin
    case (ex_in.a_fwd)
      pip_pkg::FWD_FROM_EXMEM: a_op = ex_mem_result;
      pip_pkg::FWD_FROM_MEMWB: a_op = wb_data;
      default:                 a_op = ex_in.a;
    endcase
    case (ex_in.b_fwd)
      pip_pkg::FWD_FROM_EXMEM: b_reg_val = ex_mem_result;
      pip_pkg::FWD_FROM_MEMWB: b_reg_val = wb_data;
      default:                 b_reg_val = ex_in.b; // late case patched in MEM
    endcase
  end

  assign b_op = ex_in.use_imm ? ex_in.imm : b_reg_val;
  assign sh   = ex_in.shamt | a_op[4:0]; // one of the two is zero

  always_comb begin
    case (ex_in.alu_op)
      pip_pkg::OP_ADD: alu_out = a_op + b_op;
      pip_pkg::OP_SUB: alu_out = a_op - b_op;
      pip_pkg::OP_AND: alu_out = a_op & b_op;
      pip_pkg::OP_OR:  alu_out = a_op | b_op;
      pip_pkg::OP_XOR: alu_out = a_op ^ b_op;
      pip_pkg::OP_NOR: alu_out = ~(a_op | b_op);
      pip_pkg::OP_SLL: alu_out = b_op << sh;
      pip_pkg::OP_SRL: alu_out = b_op >> sh;
      pip_pkg::OP_SRA: alu_out = $signed(b_op) >>> sh;
      pip_pkg::OP_LUI: alu_out = {b_op[15:0], 16'd0};
      default:         alu_out = a_op;
    endcase
  end

  assign set_bit = ex_in.alu_set_u ? (a_op < b_op) : ($signed(a_op) < $signed(b_op));
  assign result  = (ex_in.alu_res_sel == pip_pkg::RES_SET) ? {31'd0, set_bit} : alu_out;

  // EX/MEM
  always_ff @(posedge clock) begin
    ex_mem_result     <= result;
    ex_mem_store_data <= b_reg_val;
    ex_mem_late       <= (ex_in.b_fwd == pip_pkg::FWD_FROM_MEMWB_LATE);
    ex_mem_dest_reg   <= ex_in.dest_reg;
    if (reset) begin
      ex_mem_load       <= 1'b0;
      ex_mem_store      <= 1'b0;
      ex_mem_dest_valid <= 1'b0;
    end else begin
      ex_mem_load       <= ex_in.valid && ex_in.load;
      ex_mem_store      <= ex_in.valid && ex_in.store;
      ex_mem_dest_valid <= ex_in.valid && ex_in.dest_valid;
    end
  end

  assign dmem_addr  = ex_mem_result[pip_pkg::dmem_aw+1:2];
  assign store_data = ex_mem_late ? wb_data : ex_mem_store_data; // load just ahead

  always_ff @(posedge clock) begin
    if (ex_mem_store)
      dmem[dmem_addr] <= store_data;
  end

  // MEM/WB
  always_ff @(posedge clock) begin
    wb_data <= ex_mem_load ? dmem[dmem_addr] : ex_mem_result;
    wb_reg  <= ex_mem_dest_reg;
    if (reset)
      wb_valid <= 1'b0;
    else
      wb_valid <= ex_mem_dest_valid;
  end

endmodule

// ==== verilog/id_ex_buf.sv ====
`timescale 1ns/1ps

module id_ex_buf (
  input  logic    clock,
  input  logic    reset,
  input  logic    stall,
  id_ex_if.sink   dec_out,
  id_ex_if.source ex_in
);

  always_ff @(posedge clock) begin
    ex_in.a           <= dec_out.a;
    ex_in.b           <= dec_out.b;
    ex_in.imm         <= dec_out.imm;
    ex_in.use_imm     <= dec_out.use_imm;
    ex_in.shamt       <= dec_out.shamt;
    ex_in.alu_op      <= dec_out.alu_op;
    ex_in.alu_res_sel <= dec_out.alu_res_sel;
    ex_in.alu_set_u   <= dec_out.alu_set_u;
    ex_in.a_fwd       <= dec_out.a_fwd;
    ex_in.b_fwd       <= dec_out.b_fwd;
    ex_in.dest_reg    <= dec_out.dest_reg;
    if (reset || stall) begin // bubble
      ex_in.valid      <= 1'b0;
      ex_in.load       <= 1'b0;
      ex_in.store      <= 1'b0;
      ex_in.dest_valid <= 1'b0;
    end else begin
      ex_in.valid      <= dec_out.valid;
      ex_in.load       <= dec_out.load;
      ex_in.store      <= dec_out.store;
      ex_in.dest_valid <= dec_out.dest_valid;
    end
  end

endmodule

// ==== verilog/inst_decode.sv ====
`timescale 1ns/1ps

module inst_decode (
  input  pip_pkg::inst_t inst,
  input  logic           inst_valid,
  input  logic [31:0]    rd_data1,
  input  logic [31:0]    rd_data2,
  id_ex_if.hazard        ex_in,
  input  logic [4:0]     ex_mem_dest_reg,
  input  logic           ex_mem_dest_valid,
  output logic [4:0]     rd_addr1,
  output logic [4:0]     rd_addr2,
  output logic           stall,
  id_ex_if.decode        dec_out
);

  logic known, a_used, b_used, b_late, imm_sext, dest_ok, is_load, is_store;
  logic a_need, b_need;
  logic a_match_idex, b_match_idex, a_match_exmem, b_match_exmem;
  logic [4:0] dest;

  always_comb begin
    known    = 1'b1;
    a_used   = 1'b1;
    b_used   = 1'b0;
    b_late   = 1'b0;
    imm_sext = 1'b0;
    dest_ok  = 1'b1;
    is_load  = 1'b0;
    is_store = 1'b0;
    dest     = inst.i.rt;
    dec_out.use_imm     = 1'b1;
    dec_out.shamt       = 5'd0;
    dec_out.alu_op      = pip_pkg::OP_PASS_A;
    dec_out.alu_res_sel = pip_pkg::RES_ALU;
    dec_out.alu_set_u   = 1'b0;

    case (inst.r.opc)
      pip_pkg::OPC_RTYPE: begin
        dest            = inst.r.rd;
        b_used          = 1'b1;
        dec_out.use_imm = 1'b0;
        case (inst.r.funct)
          pip_pkg::FN_SLL, pip_pkg::FN_SLLV: dec_out.alu_op = pip_pkg::OP_SLL;
          pip_pkg::FN_SRL, pip_pkg::FN_SRLV: dec_out.alu_op = pip_pkg::OP_SRL;
          pip_pkg::FN_SRA, pip_pkg::FN_SRAV: dec_out.alu_op = pip_pkg::OP_SRA;
          pip_pkg::FN_ADD, pip_pkg::FN_ADDU: dec_out.alu_op = pip_pkg::OP_ADD;
          pip_pkg::FN_SUB, pip_pkg::FN_SUBU: dec_out.alu_op = pip_pkg::OP_SUB;
          pip_pkg::FN_AND: dec_out.alu_op = pip_pkg::OP_AND;
          pip_pkg::FN_OR:  dec_out.alu_op = pip_pkg::OP_OR;
          pip_pkg::FN_XOR: dec_out.alu_op = pip_pkg::OP_XOR;
          pip_pkg::FN_NOR: dec_out.alu_op = pip_pkg::OP_NOR;
          pip_pkg::FN_SLT, pip_pkg::FN_SLTU: begin
            dec_out.alu_op      = pip_pkg::OP_SUB;
            dec_out.alu_res_sel = pip_pkg::RES_SET;
            dec_out.alu_set_u   = (inst.r.funct == pip_pkg::FN_SLTU);
          end
          default: known = 1'b0;
        endcase
        if (inst.r.funct[5:2] == 4'd0) begin // sll, srl, sra take shamt
          a_used        = 1'b0;
          dec_out.shamt = inst.r.shamt;
        end
      end
      pip_pkg::OPC_ADDI, pip_pkg::OPC_ADDIU: begin
        dec_out.alu_op = pip_pkg::OP_ADD;
        imm_sext       = 1'b1;
      end
      pip_pkg::OPC_SLTI, pip_pkg::OPC_SLTIU: begin
        dec_out.alu_op      = pip_pkg::OP_SUB;
        dec_out.alu_res_sel = pip_pkg::RES_SET;
        dec_out.alu_set_u   = (inst.i.opc == pip_pkg::OPC_SLTIU);
        imm_sext            = 1'b1;
      end
      pip_pkg::OPC_ANDI: dec_out.alu_op = pip_pkg::OP_AND;
      pip_pkg::OPC_ORI:  dec_out.alu_op = pip_pkg::OP_OR;
      pip_pkg::OPC_XORI: dec_out.alu_op = pip_pkg::OP_XOR;
      pip_pkg::OPC_LUI: begin
        dec_out.alu_op = pip_pkg::OP_LUI;
        a_used         = 1'b0;
      end
      pip_pkg::OPC_LW: begin
        dec_out.alu_op = pip_pkg::OP_ADD;
        imm_sext       = 1'b1;
        is_load        = 1'b1;
      end
      pip_pkg::OPC_SW: begin
        dec_out.alu_op = pip_pkg::OP_ADD;
        imm_sext       = 1'b1;
        is_store       = 1'b1;
        b_used         = 1'b1;
        b_late         = 1'b1; // store data only needed in MEM
        dest_ok        = 1'b0;
      end
      default: known = 1'b0;
    endcase
  end

  assign dec_out.valid      = inst_valid && known;
  assign dec_out.load       = dec_out.valid && is_load;
  assign dec_out.store      = dec_out.valid && is_store;
  assign dec_out.dest_reg   = dest;
  assign dec_out.dest_valid = dec_out.valid && dest_ok && (dest != 5'd0);

  assign a_need = dec_out.valid && a_used;
  assign b_need = dec_out.valid && b_used;

  assign rd_addr1 = inst.r.rs;
  assign rd_addr2 = inst.r.rt;

  // unused A is zero so exec can merge shamt and A[4:0]
  assign dec_out.a   = a_need ? rd_data1 : 32'd0;
  assign dec_out.b   = rd_data2;
  assign dec_out.imm = imm_sext ? {{16{inst.i.imm[15]}}, inst.i.imm} : {16'd0, inst.i.imm};

  assign a_match_idex  = ex_in.dest_valid && a_need && (inst.r.rs == ex_in.dest_reg);
  assign b_match_idex  = ex_in.dest_valid && b_need && (inst.r.rt == ex_in.dest_reg);
  assign a_match_exmem = ex_mem_dest_valid && a_need && (inst.r.rs == ex_mem_dest_reg);
  assign b_match_exmem = ex_mem_dest_valid && b_need && (inst.r.rt == ex_mem_dest_reg);

  always_comb begin
    if (a_match_idex)
      dec_out.a_fwd = pip_pkg::FWD_FROM_EXMEM;
    else if (a_match_exmem)
      dec_out.a_fwd = pip_pkg::FWD_FROM_MEMWB;
    else
      dec_out.a_fwd = pip_pkg::FWD_NONE;

    if (b_match_idex && ex_in.load)
      dec_out.b_fwd = pip_pkg::FWD_FROM_MEMWB_LATE; // only reached by a store
    else if (b_match_idex)
      dec_out.b_fwd = pip_pkg::FWD_FROM_EXMEM;
    else if (b_match_exmem)
      dec_out.b_fwd = pip_pkg::FWD_FROM_MEMWB;
    else
      dec_out.b_fwd = pip_pkg::FWD_NONE;
  end

  assign stall = ex_in.load && (a_match_idex || (!b_late && b_match_idex));

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
  input  logic        clock,
  input  logic        reset,
  input  logic [4:0]  rd_addr1,
  input  logic [4:0]  rd_addr2,
  input  logic        wr_en,
  input  logic [4:0]  wr_addr,
  input  logic [31:0] wr_data,
  output logic [31:0] rd_data1,
  output logic [31:0] rd_data2
);

  logic [31:0] regs [32];
  logic        wr_live;

  assign wr_live = wr_en && (wr_addr != 5'd0); // r0 stays zero

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++)
        regs[i] <= 32'd0;
    end else if (wr_live) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // write-through for the instruction in decode
  assign rd_data1 = (wr_live && wr_addr == rd_addr1) ? wr_data : regs[rd_addr1];
  assign rd_data2 = (wr_live && wr_addr == rd_addr2) ? wr_data : regs[rd_addr2];

endmodule

// ==== verilog/inst_fetch.sv ====
`timescale 1ns/1ps

module inst_fetch (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       run,
  input  logic                       stall,
  input  logic                       imem_we,
  input  logic [pip_pkg::imem_aw-1:0] imem_addr,
  input  logic [31:0]                imem_wdata,
  output pip_pkg::inst_t             inst,
  output logic                       inst_valid
);

  logic [31:0]                   imem [pip_pkg::imem_words];
  logic [pip_pkg::imem_words-1:0] loaded; // words written since reset
  logic [pip_pkg::imem_aw:0]     pc;      // top bit set once past the memory
  logic [31:0]                   word;

  always_ff @(posedge clock) begin
    if (imem_we)
      imem[imem_addr] <= imem_wdata;
  end

  always_ff @(posedge clock) begin
    if (reset)
      loaded <= '0;
    else if (imem_we)
      loaded[imem_addr] <= 1'b1;
  end

  // unloaded or out of range reads as sll r0, a no-op
  assign word = (!pc[pip_pkg::imem_aw] && loaded[pc[pip_pkg::imem_aw-1:0]]) ?
                imem[pc[pip_pkg::imem_aw-1:0]] : 32'd0;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc         <= '0;
      inst_valid <= 1'b0;
    end else if (!stall) begin
      inst_valid <= run;
      if (run && !pc[pip_pkg::imem_aw])
        pc <= pc + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (run && !stall)
      inst <= word; // IF/ID holds on stall
  end

endmodule

// ==== verilog/id_ex_if.sv ====
`timescale 1ns/1ps

interface id_ex_if;
  logic              valid;
  logic [31:0]       a;
  logic [31:0]       b;
  logic [31:0]       imm;
  logic              use_imm;
  logic [4:0]        shamt;
  pip_pkg::alu_op_t  alu_op;
  pip_pkg::alu_res_t alu_res_sel;
  logic              alu_set_u;
  pip_pkg::fwd_t     a_fwd;
  pip_pkg::fwd_t     b_fwd;
  logic              load;
  logic              store;
  logic [4:0]        dest_reg;
  logic              dest_valid;

  modport decode (
    output valid, a, b, imm, use_imm, shamt, alu_op, alu_res_sel, alu_set_u,
    output a_fwd, b_fwd, load, store, dest_reg, dest_valid
  );
  modport source (
    output valid, a, b, imm, use_imm, shamt, alu_op, alu_res_sel, alu_set_u,
    output a_fwd, b_fwd, load, store, dest_reg, dest_valid
  );
  modport sink (
    input valid, a, b, imm, use_imm, shamt, alu_op, alu_res_sel, alu_set_u,
    input a_fwd, b_fwd, load, store, dest_reg, dest_valid
  );
  modport hazard (input dest_reg, dest_valid, load);
endinterface

// ==== verilog/pip_pkg.sv ====
package pip_pkg;

  localparam int imem_words = 64;
  localparam int imem_aw    = 6;
  localparam int dmem_words = 16;
  localparam int dmem_aw    = 4;

  // opcodes
  localparam logic [5:0] OPC_RTYPE = 6'h00;
  localparam logic [5:0] OPC_ADDI  = 6'h08;
  localparam logic [5:0] OPC_ADDIU = 6'h09;
  localparam logic [5:0] OPC_SLTI  = 6'h0a;
  localparam logic [5:0] OPC_SLTIU = 6'h0b;
  localparam logic [5:0] OPC_ANDI  = 6'h0c;
  localparam logic [5:0] OPC_ORI   = 6'h0d;
  localparam logic [5:0] OPC_XORI  = 6'h0e;
  localparam logic [5:0] OPC_LUI   = 6'h0f;
  localparam logic [5:0] OPC_LW    = 6'h23;
  localparam logic [5:0] OPC_SW    = 6'h2b;

  // R-format function codes
  localparam logic [5:0] FN_SLL  = 6'd0;
  localparam logic [5:0] FN_SRL  = 6'd2;
  localparam logic [5:0] FN_SRA  = 6'd3;
  localparam logic [5:0] FN_SLLV = 6'd4;
  localparam logic [5:0] FN_SRLV = 6'd6;
  localparam logic [5:0] FN_SRAV = 6'd7;
  localparam logic [5:0] FN_ADD  = 6'd32;
  localparam logic [5:0] FN_ADDU = 6'd33;
  localparam logic [5:0] FN_SUB  = 6'd34;
  localparam logic [5:0] FN_SUBU = 6'd35;
  localparam logic [5:0] FN_AND  = 6'd36;
  localparam logic [5:0] FN_OR   = 6'd37;
  localparam logic [5:0] FN_XOR  = 6'd38;
  localparam logic [5:0] FN_NOR  = 6'd39;
  localparam logic [5:0] FN_SLT  = 6'd42;
  localparam logic [5:0] FN_SLTU = 6'd43;

  typedef enum logic [3:0] {
    OP_PASS_A, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
    OP_NOR, OP_SLL, OP_SRL, OP_SRA, OP_LUI
  } alu_op_t;

  typedef enum logic {RES_ALU, RES_SET} alu_res_t;

  typedef enum logic [1:0] {
    FWD_NONE, FWD_FROM_EXMEM, FWD_FROM_MEMWB, FWD_FROM_MEMWB_LATE
  } fwd_t;

  typedef struct packed {
    logic [5:0] opc;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_fmt_t;

  typedef struct packed {
    logic [5:0]  opc;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } inst_t;

endpackage
